//--- common/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // default buffer depth, any power of two
    localparam int ROB_DEPTH = 8;

    // instruction classes tracked by the buffer
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_SW     = 3'd2,
        OP_SH     = 3'd3,
        OP_SB     = 3'd4,
        OP_BRANCH = 3'd5
    } op_t;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

    // byte offset of an address within its word
    typedef logic [1:0] byte_off_t;

    // store byte enables
    typedef logic [3:0] wmask_t;

    // instruction as sent by the instruction queue
    typedef struct packed {
        op_t      op;
        reg_idx_t rd;
        reg_idx_t st_src;
        logic     pred_taken;
    } dispatch_t;

    // what one slot shows to the commit unit
    // rd holds the store source for store ops
    typedef struct packed {
        op_t      op;
        reg_idx_t rd;
        logic     pred_taken;
        logic     taken;
        logic     valid;
        logic     allocated;
    } entry_state_t;

    // commit side outputs toward regfile and store path
    typedef struct packed {
        logic     regfile_load;
        op_t      commit_type;
        reg_idx_t rd_commit;
        reg_idx_t st_src_commit;
        wmask_t   wmask;
    } commit_t;

endpackage : rob_pkg

`default_nettype wire

//--- rob/rob_alloc.sv
`timescale 1ns/10ps
`default_nettype none

module rob_alloc #(
    parameter int DEPTH = rob_pkg::ROB_DEPTH,
    localparam int TAG_W = $clog2(DEPTH)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                rob_load,
    input  rob_pkg::dispatch_t  dispatch,
    input  logic [DEPTH-1:0]    set_rob_valid,
    input  logic [TAG_W-1:0]    br_entry,
    input  logic                br_taken,
    input  logic                update_br,
    input  logic [DEPTH-1:0]    allocated,
    input  logic                mispredict,
    input  logic [TAG_W-1:0]    head_ptr,
    output logic [TAG_W-1:0]    curr_ptr,
    output logic [DEPTH-1:0]    alloc_we,
    output logic [DEPTH-1:0]    set_valid,
    output logic [DEPTH-1:0]    br_update,
    output rob_pkg::dispatch_t  entry_data,
    output logic                taken,
    output logic                rob_full
);

    // tail pointer
    // squash restarts allocation right behind the mispredicted branch
    always_ff @(posedge clk) begin
        if (rst) begin
            curr_ptr <= '0;
        end else if (mispredict) begin
            curr_ptr <= head_ptr + 1'b1;
        end else if (rob_load) begin
            curr_ptr <= curr_ptr + 1'b1;
        end
    end

    // one-hot strobes toward the slots
    always_comb begin
        alloc_we  = '0;
        br_update = '0;
        if (rob_load) begin
            alloc_we[curr_ptr] = 1'b1;
        end
        if (update_br) begin
            br_update[br_entry] = 1'b1;
        end
    end

    // completion only counts for live slots
    assign set_valid = set_rob_valid & allocated;

    // branch outcome shared by all slots, strobe picks the target
    assign taken = br_taken;

    // stores keep their data source in the register field
    always_comb begin
        entry_data = dispatch;
        if (dispatch.op inside {rob_pkg::OP_SW, rob_pkg::OP_SH, rob_pkg::OP_SB}) begin
            entry_data.rd = dispatch.st_src;
        end
    end

    // full when every slot is taken, or while squashing
    assign rob_full = (&allocated) | mispredict;

endmodule : rob_alloc

`default_nettype wire

//--- rob/rob_entry.sv
`timescale 1ns/10ps
`default_nettype none

module rob_entry (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alloc_we,
    input  rob_pkg::dispatch_t     entry_data,
    input  logic                   set_valid,
    input  logic                   br_update,
    input  logic                   taken,
    input  logic                   commit_clear,
    input  logic                   squash,
    output rob_pkg::entry_state_t  state
);

    // control state
    logic allocated_q;
    logic valid_q;
    logic taken_q;

    // instruction record
    rob_pkg::op_t      op_q;
    rob_pkg::reg_idx_t rd_q;
    logic              pred_q;

    // slot lifetime
    // clear wins over everything, then allocate, then updates
    always_ff @(posedge clk) begin
        if (rst) begin
            allocated_q <= 1'b0;
            valid_q     <= 1'b0;
            taken_q     <= 1'b0;
        end else if (commit_clear || squash) begin
            allocated_q <= 1'b0;
            valid_q     <= 1'b0;
            taken_q     <= 1'b0;
        end else if (alloc_we) begin
            allocated_q <= 1'b1;
            valid_q     <= 1'b0;
            // outcome starts as not taken
            taken_q     <= 1'b0;
        end else begin
            if (set_valid && allocated_q) begin
                valid_q <= 1'b1;
            end
            // branch unit result
            if (br_update && allocated_q) begin
                taken_q <= taken;
            end
        end
    end

    // record is only written on allocate
    always_ff @(posedge clk) begin
        if (alloc_we) begin
            op_q   <= entry_data.op;
            rd_q   <= entry_data.rd;
            pred_q <= entry_data.pred_taken;
        end
    end

    assign state.op         = op_q;
    assign state.rd         = rd_q;
    assign state.pred_taken = pred_q;
    assign state.taken      = taken_q;
    assign state.valid      = valid_q;
    assign state.allocated  = allocated_q;

endmodule : rob_entry

`default_nettype wire

//--- rob/rob_commit.sv
`timescale 1ns/10ps
`default_nettype none

module rob_commit #(
    parameter int DEPTH = rob_pkg::ROB_DEPTH,
    localparam int TAG_W = $clog2(DEPTH)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  rob_pkg::entry_state_t  entries [DEPTH],
    input  rob_pkg::byte_off_t     memaddr_offset,
    output logic [TAG_W-1:0]       head_ptr,
    output logic [DEPTH-1:0]       commit_clear,
    output logic                   squash,
    output logic                   mispredict,
    output logic                   ld_pc,
    output rob_pkg::commit_t       commit
);

    rob_pkg::entry_state_t head;
    logic head_ready;
    logic do_commit;
    logic writes_reg;

    // oldest instruction
    assign head = entries[head_ptr];

    // completed and still live
    assign head_ready = head.valid & head.allocated;

    // branch at head disagrees with its prediction
    assign mispredict = head_ready
                      & (head.op == rob_pkg::OP_BRANCH)
                      & (head.pred_taken != head.taken);

    // normal retirement, a mispredict replaces it
    assign do_commit = head_ready & ~mispredict;

    // only alu and load results go to the regfile
    assign writes_reg = head.op inside {rob_pkg::OP_ALU, rob_pkg::OP_LOAD};

    // head advances by one on commit and on mispredict alike
    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
        end else if (head_ready) begin
            head_ptr <= head_ptr + 1'b1;
        end
    end

    // free the retiring slot
    always_comb begin
        commit_clear = '0;
        if (do_commit) begin
            commit_clear[head_ptr] = 1'b1;
        end
    end

    // whole buffer goes on a mispredict
    assign squash = mispredict;
    // redirect fetch for one cycle
    assign ld_pc  = mispredict;

    // commit bundle
    always_comb begin
        commit.regfile_load  = do_commit & writes_reg;
        commit.commit_type   = head.op;
        commit.rd_commit     = head.rd;
        // stores hold their source in the register field
        commit.st_src_commit = head.rd;
        commit.wmask         = '0;
        if (do_commit) begin
            case (head.op)
                rob_pkg::OP_SW: commit.wmask = 4'b1111;
                // halfword lanes picked by the address offset
                rob_pkg::OP_SH: commit.wmask = 4'b0011 << memaddr_offset;
                rob_pkg::OP_SB: commit.wmask = 4'b0001 << memaddr_offset;
                default:        commit.wmask = '0;
            endcase
        end
    end

endmodule : rob_commit

`default_nettype wire

//--- rob/rob_top.sv
`timescale 1ns/10ps
`default_nettype none

module rob_top #(
    parameter int DEPTH = rob_pkg::ROB_DEPTH,
    localparam int TAG_W = $clog2(DEPTH)
) (
    input  logic                clk,
    input  logic                rst,
    // dispatch from the instruction queue
    input  logic                rob_load,
    input  rob_pkg::dispatch_t  dispatch,
    output logic [TAG_W-1:0]    curr_ptr,
    // completion pulses from the reservation stations
    input  logic [DEPTH-1:0]    set_rob_valid,
    // branch unit result
    input  logic                update_br,
    input  logic [TAG_W-1:0]    br_entry,
    input  logic                br_taken,
    // address offset of the head store
    input  rob_pkg::byte_off_t  memaddr_offset,
    output logic [TAG_W-1:0]    head_ptr,
    output logic                rob_full,
    output logic [DEPTH-1:0]    status_rob_valid,
    output logic [DEPTH-1:0]    allocated_rob_entries,
    output rob_pkg::commit_t    commit,
    output logic                ld_pc
);

    // allocator to slots
    logic [DEPTH-1:0]      alloc_we;
    logic [DEPTH-1:0]      set_valid;
    logic [DEPTH-1:0]      br_update;
    rob_pkg::dispatch_t    entry_data;
    logic                  taken;

    // slots to commit unit
    rob_pkg::entry_state_t entries [DEPTH];

    // commit unit back to slots and allocator
    logic [DEPTH-1:0]      commit_clear;
    logic                  squash;
    logic                  mispredict;

    rob_alloc #(
        .DEPTH(DEPTH)
    ) u_alloc (
        .clk          (clk),
        .rst          (rst),
        .rob_load     (rob_load),
        .dispatch     (dispatch),
        .set_rob_valid(set_rob_valid),
        .br_entry     (br_entry),
        .br_taken     (br_taken),
        .update_br    (update_br),
        .allocated    (allocated_rob_entries),
        .mispredict   (mispredict),
        .head_ptr     (head_ptr),
        .curr_ptr     (curr_ptr),
        .alloc_we     (alloc_we),
        .set_valid    (set_valid),
        .br_update    (br_update),
        .entry_data   (entry_data),
        .taken        (taken),
        .rob_full     (rob_full)
    );

    // one slot per tag
    for (genvar i = 0; i < DEPTH; i++) begin : g_entry
        rob_entry u_entry (
            .clk         (clk),
            .rst         (rst),
            .alloc_we    (alloc_we[i]),
            .entry_data  (entry_data),
            .set_valid   (set_valid[i]),
            .br_update   (br_update[i]),
            .taken       (taken),
            .commit_clear(commit_clear[i]),
            .squash      (squash),
            .state       (entries[i])
        );

        // status vectors for the outside
        assign allocated_rob_entries[i] = entries[i].allocated;
        assign status_rob_valid[i]      = entries[i].valid;
    end

    rob_commit #(
        .DEPTH(DEPTH)
    ) u_commit (
        .clk           (clk),
        .rst           (rst),
        .entries       (entries),
        .memaddr_offset(memaddr_offset),
        .head_ptr      (head_ptr),
        .commit_clear  (commit_clear),
        .squash        (squash),
        .mispredict    (mispredict),
        .ld_pc         (ld_pc),
        .commit        (commit)
    );

endmodule : rob_top

`default_nettype wire

//--- sim/rob_props.sv
`timescale 1ns/10ps
`default_nettype none

module rob_props (
    input logic clk,
    input logic rst,
    input logic rob_load,
    input logic rob_full,
    input logic ld_pc,
    input logic regfile_load
);

    // dispatch holds off while the buffer is full
    a_no_load_when_full: assert property (
        @(posedge clk) disable iff (rst) rob_full |-> !rob_load
    ) else $error("rob_load raised while rob_full is high");

    // redirect is a single cycle pulse
    a_ld_pc_pulse: assert property (
        @(posedge clk) disable iff (rst) ld_pc |=> !ld_pc
    ) else $error("ld_pc held longer than one cycle");

    // neither the squashing branch nor any squashed slot writes the regfile
    a_no_write_on_flush: assert property (
        @(posedge clk) disable iff (rst) ld_pc |-> !regfile_load ##1 !regfile_load
    ) else $error("regfile_load raised with ld_pc or in the cycle after it");

endmodule : rob_props

bind rob_top rob_props u_props (
    .clk         (clk),
    .rst         (rst),
    .rob_load    (rob_load),
    .rob_full    (rob_full),
    .ld_pc       (ld_pc),
    .regfile_load(commit.regfile_load)
);

`default_nettype wire

//--- sim/rob_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module rob_clkgen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset held over the first rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule : rob_clkgen

`default_nettype wire

//--- sim/rob_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rob_tb;

    localparam int DEPTH   = rob_pkg::ROB_DEPTH;
    localparam int TAG_W   = $clog2(DEPTH);
    localparam int N_BATCH = 12;
    // random batches plus full, store and branch tests, then doubled
    localparam int TEST_CYCLES = 10 + N_BATCH * 4 * DEPTH + 300;
    localparam int TIMEOUT_NS  = 2 * TEST_CYCLES * 4;

    typedef logic [TAG_W-1:0] tag_t;

    logic                 clk;
    logic                 rst;
    logic                 rob_load;
    rob_pkg::dispatch_t   disp;
    tag_t                 curr_ptr;
    logic [DEPTH-1:0]     set_rob_valid;
    logic                 update_br;
    tag_t                 br_entry;
    logic                 br_taken;
    rob_pkg::byte_off_t   memaddr_offset;
    tag_t                 head_ptr;
    logic                 rob_full;
    logic [DEPTH-1:0]     status_rob_valid;
    logic [DEPTH-1:0]     allocated_rob_entries;
    rob_pkg::commit_t     commit;
    logic                 ld_pc;

    // reference model state per tag
    rob_pkg::op_t      m_op    [DEPTH];
    rob_pkg::reg_idx_t m_reg   [DEPTH];
    logic              m_pred  [DEPTH];
    logic              m_taken [DEPTH];
    logic              m_valid [DEPTH];
    logic              m_alloc [DEPTH];
    tag_t              m_head;
    tag_t              m_tail;

    rob_clkgen #(.PERIOD_NS(4), .RESET_CYCLES(5)) u_clkgen (.clk(clk), .rst(rst));

    rob_top #(.DEPTH(DEPTH)) uut (
        .clk(clk), .rst(rst), .rob_load(rob_load), .dispatch(disp), .curr_ptr(curr_ptr),
        .set_rob_valid(set_rob_valid), .update_br(update_br), .br_entry(br_entry),
        .br_taken(br_taken), .memaddr_offset(memaddr_offset), .head_ptr(head_ptr),
        .rob_full(rob_full), .status_rob_valid(status_rob_valid),
        .allocated_rob_entries(allocated_rob_entries), .commit(commit), .ld_pc(ld_pc)
    );

    task automatic end_with_failure();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_commit(input string name, input rob_pkg::commit_t exp,
                                input rob_pkg::commit_t act, input logic active);
        // idle or squash cycles only promise no write and no store mask
        if (active ? (act !== exp)
                   : ({act.regfile_load, act.wmask} !== {exp.regfile_load, exp.wmask})) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_vec(input string name, input logic [DEPTH-1:0] exp,
                             input logic [DEPTH-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    function automatic logic model_full();
        logic f;
        f = 1'b1;
        for (int i = 0; i < DEPTH; i++) f &= m_alloc[i];
        return f;
    endfunction

    function automatic logic model_empty();
        logic e;
        e = 1'b1;
        for (int i = 0; i < DEPTH; i++) e &= ~m_alloc[i];
        return e;
    endfunction

    // per slot model flags gathered into one vector, bit i for tag i
    function automatic logic [DEPTH-1:0] pack_flags(input logic flags [DEPTH]);
        logic [DEPTH-1:0] v;
        for (int i = 0; i < DEPTH; i++) begin
            v[i] = flags[i];
        end
        return v;
    endfunction

    // next commit bundle from the head of the model
    function automatic rob_pkg::commit_t expected_commit(input rob_pkg::byte_off_t off,
                                                         output logic flush,
                                                         output logic active);
        rob_pkg::commit_t e;
        tag_t h;
        e      = '0;
        flush  = 1'b0;
        active = 1'b0;
        h      = m_head;
        if (m_alloc[h] && m_valid[h]) begin
            if (m_op[h] == rob_pkg::OP_BRANCH && m_pred[h] != m_taken[h]) begin
                flush = 1'b1;
            end else begin
                active          = 1'b1;
                e.regfile_load  = (m_op[h] == rob_pkg::OP_ALU) || (m_op[h] == rob_pkg::OP_LOAD);
                e.commit_type   = m_op[h];
                e.rd_commit     = m_reg[h];
                e.st_src_commit = m_reg[h];
                case (m_op[h])
                    rob_pkg::OP_SW: e.wmask = 4'b1111;
                    rob_pkg::OP_SH: e.wmask = rob_pkg::wmask_t'(4'b0011 << off);
                    rob_pkg::OP_SB: e.wmask = rob_pkg::wmask_t'(4'b0001 << off);
                    default:        e.wmask = '0;
                endcase
            end
        end
        return e;
    endfunction

    // model state after one rising edge
    task automatic advance_model(input logic flush, input logic active);
        tag_t h;
        h = m_head;
        // completion and branch outcome only for live slots
        for (int i = 0; i < DEPTH; i++) begin
            if (m_alloc[i] && set_rob_valid[i]) m_valid[i] = 1'b1;
            if (m_alloc[i] && update_br && br_entry == i) m_taken[i] = br_taken;
        end
        if (flush) begin
            for (int i = 0; i < DEPTH; i++) begin
                m_alloc[i] = 1'b0;
                m_valid[i] = 1'b0;
            end
            m_head = h + 1'b1;
            m_tail = h + 1'b1;
        end else if (active) begin
            m_alloc[h] = 1'b0;
            m_valid[h] = 1'b0;
            m_head     = h + 1'b1;
        end
        if (rob_load && !flush) begin
            m_alloc[m_tail] = 1'b1;
            m_valid[m_tail] = 1'b0;
            m_taken[m_tail] = 1'b0;
            m_op[m_tail]    = disp.op;
            m_pred[m_tail]  = disp.pred_taken;
            // stores keep their source register in place of rd
            m_reg[m_tail]   = (disp.op inside {rob_pkg::OP_SW, rob_pkg::OP_SH, rob_pkg::OP_SB})
                            ? disp.st_src : disp.rd;
            m_tail          = m_tail + 1'b1;
        end
    endtask

    // compare on every rising edge, then step the model
    always @(posedge clk) begin
        rob_pkg::commit_t exp;
        logic exp_flush;
        logic exp_active;
        if (rst) begin
            m_head = '0;
            m_tail = '0;
            for (int i = 0; i < DEPTH; i++) begin
                m_alloc[i] = 1'b0;
                m_valid[i] = 1'b0;
            end
        end else begin
            exp = expected_commit(memaddr_offset, exp_flush, exp_active);
            check_commit("commit", exp, commit, exp_active);
            check_bit("ld_pc", exp_flush, ld_pc);
            check_bit("rob_full", model_full() || exp_flush, rob_full);
            check_tag("head_ptr", m_head, head_ptr);
            check_tag("curr_ptr", m_tail, curr_ptr);
            check_vec("status_rob_valid", pack_flags(m_valid), status_rob_valid);
            check_vec("allocated_rob_entries", pack_flags(m_alloc), allocated_rob_entries);
            advance_model(exp_flush, exp_active);
        end
    end

    // next falling edge drops all pulses and picks a new store offset
    task automatic step();
        @(negedge clk);
        rob_load       = 1'b0;
        set_rob_valid  = '0;
        update_br      = 1'b0;
        memaddr_offset = rob_pkg::byte_off_t'($urandom_range(0, 3));
    endtask

    task automatic send_instr(input rob_pkg::op_t op, input rob_pkg::reg_idx_t rd,
                              input rob_pkg::reg_idx_t src, input logic pred,
                              output tag_t tag);
        step();
        while (rob_full) step();
        tag             = m_tail;
        rob_load        = 1'b1;
        disp.op         = op;
        disp.rd         = rd;
        disp.st_src     = src;
        disp.pred_taken = pred;
    endtask

    task automatic complete(input tag_t tag);
        step();
        set_rob_valid[tag] = 1'b1;
    endtask

    task automatic resolve_branch(input tag_t tag, input logic tk);
        step();
        update_br = 1'b1;
        br_entry  = tag;
        br_taken  = tk;
    endtask

    task automatic drain();
        step();
        while (!model_empty()) step();
    endtask

    function automatic rob_pkg::op_t random_store_op();
        case ($urandom_range(0, 2))
            0:       return rob_pkg::OP_SW;
            1:       return rob_pkg::OP_SH;
            default: return rob_pkg::OP_SB;
        endcase
    endfunction

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        end_with_failure();
    end

    initial begin
        int   n;
        int   j;
        logic p;
        tag_t t;
        tag_t t_br;
        tag_t tags[$];
        rob_pkg::op_t op;
        void'($urandom(83));
        rob_load = 1'b0;
        disp = '0;
        set_rob_valid = '0;
        update_br = 1'b0;
        br_entry = '0;
        br_taken = 1'b0;
        memaddr_offset = '0;
        wait (rst === 1'b0);

        // reset state
        step();
        check_tag("head_ptr", '0, head_ptr);
        check_tag("curr_ptr", '0, curr_ptr);
        check_bit("rob_full", 1'b0, rob_full);
        check_bit("regfile_load", 1'b0, commit.regfile_load);
        check_bit("ld_pc", 1'b0, ld_pc);
        check_bit("any allocated", 1'b0, |allocated_rob_entries);

        // alu and load batches completed out of order
        for (int b = 0; b < N_BATCH; b++) begin
            n = $urandom_range(1, DEPTH);
            tags.delete();
            for (int k = 0; k < n; k++) begin
                op = ($urandom_range(0, 1) == 0) ? rob_pkg::OP_ALU : rob_pkg::OP_LOAD;
                send_instr(op, rob_pkg::reg_idx_t'($urandom), '0, 1'b0, t);
                tags.push_back(t);
            end
            for (int k = n - 1; k > 0; k--) begin
                j = $urandom_range(0, k);
                t = tags[k];
                tags[k] = tags[j];
                tags[j] = t;
            end
            foreach (tags[k]) complete(tags[k]);
            drain();
        end

        // fill up, free the head, reuse its tag
        tags.delete();
        for (int k = 0; k < DEPTH; k++) begin
            send_instr(rob_pkg::OP_ALU, rob_pkg::reg_idx_t'(k), '0, 1'b0, t);
            tags.push_back(t);
        end
        step();
        check_bit("rob_full", 1'b1, rob_full);
        complete(tags[0]);
        send_instr(rob_pkg::OP_LOAD, 5'd9, '0, 1'b0, t);
        check_tag("curr_ptr", tags[0], curr_ptr);
        tags[0] = t;
        foreach (tags[k]) complete(tags[k]);
        drain();

        // stores with random offsets
        repeat (4) begin
            tags.delete();
            for (int k = 0; k < 3; k++) begin
                send_instr(random_store_op(), rob_pkg::reg_idx_t'($urandom),
                           rob_pkg::reg_idx_t'($urandom), 1'b0, t);
                tags.push_back(t);
            end
            foreach (tags[k]) complete(tags[k]);
            drain();
        end

        // correctly predicted branch
        p = $urandom_range(0, 1);
        send_instr(rob_pkg::OP_BRANCH, 5'd1, '0, p, t_br);
        send_instr(rob_pkg::OP_ALU, 5'd7, '0, 1'b0, t);
        resolve_branch(t_br, p);
        complete(t_br);
        complete(t);
        drain();

        // mispredict with completed younger entries behind it
        send_instr(rob_pkg::OP_BRANCH, 5'd2, '0, p, t_br);
        send_instr(rob_pkg::OP_ALU, 5'd11, '0, 1'b0, t);
        complete(t);
        send_instr(rob_pkg::OP_LOAD, 5'd12, '0, 1'b0, t);
        complete(t);
        resolve_branch(t_br, ~p);
        complete(t_br);
        drain();
        check_tag("head_ptr", tag_t'(t_br + 1'b1), head_ptr);
        check_tag("curr_ptr", tag_t'(t_br + 1'b1), curr_ptr);
        send_instr(rob_pkg::OP_ALU, 5'd3, '0, 1'b0, t);
        complete(t);
        drain();

        step();
        $display("Result: PASSED");
        $finish;
    end

endmodule : rob_tb

`default_nettype wire

//--- project.f
common/rob_pkg.sv
rob/rob_alloc.sv
rob/rob_entry.sv
rob/rob_commit.sv
rob/rob_top.sv
sim/rob_props.sv
sim/rob_clkgen.sv
sim/rob_tb.sv
